// ==== include/raster_cfg.svh ====
`ifndef RASTER_CFG_SVH
`define RASTER_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Frame buffer geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define RAST_SCREEN_W 640                // Visible columns.
`define RAST_SCREEN_H 480                // Visible rows.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Datapath widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define RAST_COORD_W 13                  // Signed coordinate, centred or screen.
`define RAST_COLOR_W 4                   // Palette index.
`define RAST_ADDR_W 19                   // Covers 640*480 pixels.

`endif

// ==== design/rasterPkg.sv ====
`include "raster_cfg.svh"

package rasterPkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Scalar types
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   typedef logic signed [`RAST_COORD_W-1:0] coordT;   // Signed coordinate.
   typedef logic [`RAST_COORD_W-1:0] lenT;            // Absolute delta or step count.
   typedef logic [`RAST_COORD_W:0] incT;              // Doubled delta.
   typedef logic [`RAST_COLOR_W-1:0] colorT;
   typedef logic [`RAST_ADDR_W-1:0] addrT;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Records
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   typedef struct packed {
      coordT startX;                     // Centred, Y up.
      coordT startY;
      coordT endX;
      coordT endY;
      colorT color;
   } lineCmdT;

   typedef struct packed {
      coordT originX;                    // Screen space start point.
      coordT originY;
      lenT majorLen;                     // Pixel count minus one.
      incT minorInc2;
      incT majorDec2;
      logic stepXNeg;
      logic stepYNeg;
      logic xMajor;
      colorT color;
   } lineSetupT;

   typedef struct packed {
      coordT x;                          // Screen space.
      coordT y;
      addrT address;                     // Only valid with onScreen.
      colorT color;
      logic onScreen;
      logic last;                        // Final pixel of the line.
   } pixelT;

endpackage

// ==== design/pipeStage.sv ====
module pipeStage #(
   parameter type payloadT = logic
) (
   input  logic    clk,
   input  logic    rstN,
   input  logic    inValid,
   input  payloadT inData,
   output logic    inReady,
   output logic    outValid,
   output payloadT outData,
   input  logic    outReady
);

   logic full;                           // Entry occupied.
   logic inFire;

   // Accept when empty or when the held entry leaves this cycle.
   assign inReady = !full || outReady;
   assign inFire = inValid && inReady;
   assign outValid = full;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         full <= 1'b0;
      end else if (inFire) begin
         full <= 1'b1;
      end else if (outReady) begin
         full <= 1'b0;                   // Drained with nothing behind it.
      end
   end

   always_ff @(posedge clk) begin
      if (inFire) begin
         outData <= inData;
      end
   end

endmodule

// ==== design/lineSetup.sv ====
`include "raster_cfg.svh"

module lineSetup
   import rasterPkg::*;
(
   input  logic      clk,
   input  logic      rstN,
   input  logic      capture,
   input  lineCmdT   cmd,
   output lineSetupT setup
);

   localparam int CoordW = `RAST_COORD_W;
   localparam coordT HalfW = coordT'(`RAST_SCREEN_W / 2);
   localparam coordT HalfH = coordT'(`RAST_SCREEN_H / 2);

   coordT scrStartX;
   coordT scrStartY;
   coordT scrEndX;
   coordT scrEndY;
   logic signed [CoordW:0] deltaX;       // One extra bit so the difference never wraps.
   logic signed [CoordW:0] deltaY;
   lenT absX;
   lenT absY;
   lenT majorAbs;
   lenT minorAbs;
   logic xMajor;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Centred to screen space
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   assign scrStartX = cmd.startX + HalfW;
   assign scrEndX = cmd.endX + HalfW;
   assign scrStartY = HalfH - cmd.startY;  // Screen Y grows downward.
   assign scrEndY = HalfH - cmd.endY;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Deltas and axis choice
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_comb begin
      deltaX = (CoordW + 1)'(scrEndX) - (CoordW + 1)'(scrStartX);
      deltaY = (CoordW + 1)'(scrEndY) - (CoordW + 1)'(scrStartY);
      absX = deltaX[CoordW] ? lenT'(-deltaX) : lenT'(deltaX);
      absY = deltaY[CoordW] ? lenT'(-deltaY) : lenT'(deltaY);
      xMajor = (absX >= absY);           // Ties go to X.
      majorAbs = xMajor ? absX : absY;
      minorAbs = xMajor ? absY : absX;
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         setup <= '0;
      end else if (capture) begin
         setup.originX <= scrStartX;
         setup.originY <= scrStartY;
         setup.majorLen <= majorAbs;
         setup.minorInc2 <= {minorAbs, 1'b0};
         setup.majorDec2 <= {majorAbs, 1'b0};
         setup.stepXNeg <= deltaX[CoordW];
         setup.stepYNeg <= deltaY[CoordW];
         setup.xMajor <= xMajor;
         setup.color <= cmd.color;
      end
   end

endmodule

// ==== design/bresenhamCore.sv ====
`include "raster_cfg.svh"

module bresenhamCore
   import rasterPkg::*;
(
   input  logic      clk,
   input  logic      rstN,
   input  logic      load,
   input  logic      advance,
   input  lineSetupT setup,
   output coordT     posX,
   output coordT     posY,
   output logic      lastStep
);

   // Holds up to majorLen plus minorInc2 before the subtract.
   localparam int ErrW = `RAST_COORD_W + 3;

   lenT stepCnt;                         // Major steps taken so far.
   logic signed [ErrW-1:0] err;
   logic signed [ErrW-1:0] errSum;
   logic signed [ErrW-1:0] errNext;
   logic minorStep;
   coordT xStep;
   coordT yStep;
   coordT nextX;
   coordT nextY;

   always_comb begin
      xStep = setup.stepXNeg ? coordT'(-1) : coordT'(1);
      yStep = setup.stepYNeg ? coordT'(-1) : coordT'(1);
      errSum = err + $signed(ErrW'(setup.minorInc2));
      minorStep = errSum > $signed(ErrW'(setup.majorLen));
      errNext = minorStep ? errSum - $signed(ErrW'(setup.majorDec2)) : errSum;
      // The major axis always moves, the minor one only on overflow.
      nextX = (setup.xMajor || minorStep) ? posX + xStep : posX;
      nextY = (!setup.xMajor || minorStep) ? posY + yStep : posY;
   end

   assign lastStep = (stepCnt == setup.majorLen);

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         posX <= '0;
         posY <= '0;
         stepCnt <= '0;
         err <= '0;
      end else if (load) begin
         posX <= setup.originX;          // First pixel is the start point.
         posY <= setup.originY;
         stepCnt <= '0;
         err <= '0;
      end else if (advance) begin
         posX <= nextX;
         posY <= nextY;
         stepCnt <= stepCnt + 1'b1;
         err <= errNext;
      end
   end

endmodule

// ==== design/rasterFsm.sv ====
module rasterFsm (
   input  logic clk,
   input  logic rstN,
   input  logic cmdValid,
   output logic cmdReady,
   output logic capture,
   output logic load,
   output logic advance,
   output logic pixValid,
   input  logic pixReady,
   input  logic lastStep,
   output logic lastPix
);

   typedef enum logic [1:0] {
      stIdle,
      stSetup,
      stDraw
   } stateT;

   stateT state;
   stateT stateNext;
   logic pixFire;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Handshake decode
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   assign cmdReady = (state == stIdle);
   assign capture = cmdReady && cmdValid;      // Setup registers the command.
   assign load = (state == stSetup);           // Core takes the setup result.
   assign pixValid = (state == stDraw);
   assign lastPix = pixValid && lastStep;
   assign pixFire = pixValid && pixReady;
   assign advance = pixFire && !lastStep;      // Position holds under back-pressure.

   always_comb begin
      stateNext = state;
      case (state)
         stIdle: begin
            if (capture) begin
               stateNext = stSetup;
            end
         end
         stSetup: begin
            stateNext = stDraw;
         end
         stDraw: begin
            if (pixFire && lastStep) begin
               stateNext = stIdle;             // Last pixel accepted.
            end
         end
         default: begin
            stateNext = stIdle;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         state <= stIdle;
      end else begin
         state <= stateNext;
      end
   end

endmodule

// ==== design/pixelAddresser.sv ====
`include "raster_cfg.svh"

module pixelAddresser
   import rasterPkg::*;
(
   input  coordT posX,
   input  coordT posY,
   output addrT  address,
   output logic  onScreen
);

   localparam coordT ScreenW = coordT'(`RAST_SCREEN_W);
   localparam coordT ScreenH = coordT'(`RAST_SCREEN_H);
   localparam int RowBits = $clog2(`RAST_SCREEN_H);
   localparam int ColBits = $clog2(`RAST_SCREEN_W);

   logic insideX;
   logic insideY;
   addrT row;
   addrT col;

   // Sign bit clear covers the lower bound.
   assign insideX = !posX[`RAST_COORD_W-1] && (posX < ScreenW);
   assign insideY = !posY[`RAST_COORD_W-1] && (posY < ScreenH);
   assign onScreen = insideX && insideY;

   assign row = addrT'(posY[RowBits-1:0]);
   assign col = addrT'(posX[ColBits-1:0]);

   // 640 is 512 plus 128.
   assign address = (row << 9) + (row << 7) + col;

endmodule

// ==== design/lineRasterizer.sv ====
module lineRasterizer
   import rasterPkg::*;
(
   input  logic    clk,
   input  logic    rstN,
   input  logic    cmdValid,
   input  lineCmdT cmd,
   output logic    cmdReady,
   output logic    pixValid,
   output pixelT   pix,
   input  logic    pixReady
);

   logic capture;
   logic load;
   logic advance;
   logic lastStep;
   logic lastPix;
   lineSetupT setupReg;
   coordT posX;
   coordT posY;
   addrT address;
   logic onScreen;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Setup and stepping datapath
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   lineSetup setupUnit (
      .clk     (clk),
      .rstN    (rstN),
      .capture (capture),
      .cmd     (cmd),
      .setup   (setupReg)
   );

   bresenhamCore core (
      .clk      (clk),
      .rstN     (rstN),
      .load     (load),
      .advance  (advance),
      .setup    (setupReg),
      .posX     (posX),
      .posY     (posY),
      .lastStep (lastStep)
   );

   rasterFsm control (
      .clk      (clk),
      .rstN     (rstN),
      .cmdValid (cmdValid),
      .cmdReady (cmdReady),
      .capture  (capture),
      .load     (load),
      .advance  (advance),
      .pixValid (pixValid),
      .pixReady (pixReady),
      .lastStep (lastStep),
      .lastPix  (lastPix)
   );

   pixelAddresser addresser (
      .posX     (posX),
      .posY     (posY),
      .address  (address),
      .onScreen (onScreen)
   );

   // Pixel record straight from the core position.
   always_comb begin
      pix.x = posX;
      pix.y = posY;
      pix.address = address;
      pix.color = setupReg.color;
      pix.onScreen = onScreen;
      pix.last = lastPix;
   end

endmodule

// ==== design/lineDrawTop.sv ====
module lineDrawTop
   import rasterPkg::*;
(
   input  logic    clk,
   input  logic    rstN,
   input  logic    cmdValid,
   input  lineCmdT cmd,
   output logic    cmdReady,
   output logic    pixValid,
   output pixelT   pix,
   input  logic    pixReady
);

   logic rastCmdValid;
   logic rastCmdReady;
   lineCmdT rastCmd;
   logic rastPixValid;
   logic rastPixReady;
   pixelT rastPix;

   pipeStage #(.payloadT(lineCmdT)) cmdStage (
      .clk      (clk),
      .rstN     (rstN),
      .inValid  (cmdValid),
      .inData   (cmd),
      .inReady  (cmdReady),
      .outValid (rastCmdValid),
      .outData  (rastCmd),
      .outReady (rastCmdReady)
   );

   lineRasterizer rasterizer (
      .clk      (clk),
      .rstN     (rstN),
      .cmdValid (rastCmdValid),
      .cmd      (rastCmd),
      .cmdReady (rastCmdReady),
      .pixValid (rastPixValid),
      .pix      (rastPix),
      .pixReady (rastPixReady)
   );

   pipeStage #(.payloadT(pixelT)) pixStage (
      .clk      (clk),
      .rstN     (rstN),
      .inValid  (rastPixValid),
      .inData   (rastPix),
      .inReady  (rastPixReady),
      .outValid (pixValid),
      .outData  (pix),
      .outReady (pixReady)
   );

endmodule

// ==== tests/lineDrawTb.sv ====
`include "raster_cfg.svh"

module lineDrawTb
   import rasterPkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int Seed = 32'h7c46_aa4a;
   localparam int CmdTimeout = 50000;    // Cycles to wait for cmdReady.
   localparam int DrainTimeout = 50000;  // Cycles to wait for a line to finish.
   localparam int RandLines = 40;

   logic clk;
   logic rstN;
   logic cmdValid;
   lineCmdT cmd;
   logic cmdReady;
   logic pixValid;
   pixelT pix;
   logic pixReady;
   logic bpOn;

   int seed = Seed;
   int bpSeed = Seed + 1;                // Separate stream for back-pressure.
   int rnd;
   int errors = 0;
   int lineCount = 0;
   int pixCount = 0;
   int testErr0;
   int testLine0;
   bit timedOut = 1'b0;
   pixelT expQ[$];                       // Expected pixels in order.
   lineCmdT c;

   lineDrawTop dut0 (
      .clk      (clk),
      .rstN     (rstN),
      .cmdValid (cmdValid),
      .cmd      (cmd),
      .cmdReady (cmdReady),
      .pixValid (pixValid),
      .pix      (pix),
      .pixReady (pixReady)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Sink readiness, random only while back-pressure is on.
   initial begin
      pixReady = 1'b1;
      forever begin
         @(posedge clk);
         rnd = $random(bpSeed);
         pixReady <= bpOn ? rnd[0] : 1'b1;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Reference model
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic expandLine(input lineCmdT lc);
      int x;                             // Current screen position.
      int y;
      int ex;                            // Screen end point.
      int ey;
      int dx;
      int dy;
      int ax;
      int ay;
      int major;
      int minorInc2;
      int err;
      int sx;                            // Step directions.
      int sy;
      int i;
      bit xMaj;
      pixelT p;
      x = int'(lc.startX) + `RAST_SCREEN_W / 2;
      y = `RAST_SCREEN_H / 2 - int'(lc.startY);     // Y points up in centred space.
      ex = int'(lc.endX) + `RAST_SCREEN_W / 2;
      ey = `RAST_SCREEN_H / 2 - int'(lc.endY);
      dx = ex - x;
      dy = ey - y;
      ax = (dx < 0) ? -dx : dx;
      ay = (dy < 0) ? -dy : dy;
      xMaj = (ax >= ay);
      major = xMaj ? ax : ay;
      minorInc2 = 2 * (xMaj ? ay : ax);
      sx = (dx < 0) ? -1 : 1;
      sy = (dy < 0) ? -1 : 1;
      err = 0;
      for (i = 0; i <= major; i++) begin
         p.x = coordT'(x);
         p.y = coordT'(y);
         p.onScreen = (x >= 0 && x < `RAST_SCREEN_W && y >= 0 && y < `RAST_SCREEN_H);
         p.address = addrT'(y * `RAST_SCREEN_W + x);
         p.color = lc.color;
         p.last = (i == major);
         expQ.push_back(p);
         if (xMaj) x += sx;
         else y += sy;
         err += minorInc2;
         if (err > major) begin
            if (xMaj) y += sy;
            else x += sx;
            err -= 2 * major;
         end
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Scoreboard
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic checkPixel(input pixelT got);
      pixelT exp;
      if (expQ.size() == 0) begin
         $display("Extra pixel at x %0d y %0d with no line pending", got.x, got.y);
         errors++;
         return;
      end
      exp = expQ.pop_front();
      pixCount++;
      if (got.x != exp.x) begin
         $display("MISMATCH pix.x expected %h got %h", exp.x, got.x);
         errors++;
      end
      if (got.y != exp.y) begin
         $display("MISMATCH pix.y expected %h got %h", exp.y, got.y);
         errors++;
      end
      if (got.onScreen != exp.onScreen) begin
         $display("MISMATCH pix.onScreen expected %h got %h", exp.onScreen, got.onScreen);
         errors++;
      end
      if (exp.onScreen && got.address != exp.address) begin
         $display("MISMATCH pix.address expected %h got %h", exp.address, got.address);
         errors++;
      end
      if (got.color != exp.color) begin
         $display("MISMATCH pix.color expected %h got %h", exp.color, got.color);
         errors++;
      end
      if (got.last != exp.last) begin
         $display("MISMATCH pix.last expected %h got %h", exp.last, got.last);
         errors++;
      end
   endtask

   always @(posedge clk) begin
      if (rstN && pixValid && pixReady) begin
         checkPixel(pix);
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Stimulus helpers
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   function automatic lineCmdT makeCmd(input int x0, y0, x1, y1, col);
      lineCmdT r;
      r.startX = coordT'(x0);
      r.startY = coordT'(y0);
      r.endX = coordT'(x1);
      r.endY = coordT'(y1);
      r.color = colorT'(col);
      return r;
   endfunction

   task automatic pickRange(input int lo, input int hi, output int v);
      v = lo + int'($unsigned($random(seed)) % (hi - lo + 1));
   endtask

   task automatic randLine(input int loX, hiX, loY, hiY, output lineCmdT r);
      int x0;
      int y0;
      int x1;
      int y1;
      int col;
      pickRange(loX, hiX, x0);
      pickRange(loY, hiY, y0);
      pickRange(loX, hiX, x1);
      pickRange(loY, hiY, y1);
      pickRange(0, 15, col);
      r = makeCmd(x0, y0, x1, y1, col);
   endtask

   // Offers a command and returns on the clock edge that accepts it.
   task automatic sendLine(input lineCmdT lc);
      int waitCnt;
      if (timedOut) return;
      cmdValid <= 1'b1;
      cmd <= lc;
      waitCnt = 0;
      do begin
         @(posedge clk);
         waitCnt++;
      end while (!cmdReady && waitCnt < CmdTimeout);
      if (!cmdReady) begin
         $display("Timeout: command not accepted within %0d cycles", CmdTimeout);
         timedOut = 1'b1;
      end else begin
         expandLine(lc);
         lineCount++;
      end
   endtask

   task automatic drain();
      int waitCnt;
      cmdValid <= 1'b0;
      if (timedOut) return;
      waitCnt = 0;
      while (expQ.size() != 0 && waitCnt < DrainTimeout) begin
         @(posedge clk);
         waitCnt++;
      end
      if (expQ.size() != 0) begin
         $display("Timeout: %0d pixels still missing after %0d cycles", expQ.size(),
                  DrainTimeout);
         timedOut = 1'b1;
      end
      repeat (4) @(posedge clk);         // Room for a stray extra pixel to show up.
   endtask

   task automatic startTest();
      testErr0 = errors;
      testLine0 = lineCount;
   endtask

   task automatic finishTest(input string name);
      $display("Test %s done: %0d lines, %0d errors", name, lineCount - testLine0,
               errors - testErr0);
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Test sequence
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   initial begin
      rstN = 1'b0;
      cmdValid = 1'b0;
      cmd = '0;
      bpOn = 1'b0;
      repeat (2) @(posedge clk);
      rstN <= 1'b1;
      @(posedge clk);
      if (pixValid !== 1'b0 || cmdReady !== 1'b1) begin
         $display("After reset the DUT is not idle with cmdReady high and pixValid low");
         errors++;
      end

      startTest();
      sendLine(makeCmd(-100, 0, 100, 0, 1));
      sendLine(makeCmd(100, 5, -100, 5, 2));
      sendLine(makeCmd(0, -100, 0, 100, 3));
      sendLine(makeCmd(7, 100, 7, -100, 4));
      sendLine(makeCmd(-50, -50, 50, 50, 5));
      sendLine(makeCmd(50, 50, -50, -50, 6));
      sendLine(makeCmd(50, -50, -50, 50, 7));
      sendLine(makeCmd(-50, 50, 50, -50, 8));
      drain();
      finishTest("axis and diagonal");

      startTest();
      repeat (RandLines) begin
         randLine(-320, 319, -239, 240, c);
         sendLine(c);
         drain();
      end
      finishTest("random on-screen");

      startTest();
      repeat (12) begin
         randLine(-1000, 1000, -1000, 1000, c);
         sendLine(c);
      end
      drain();
      finishTest("off-screen");

      startTest();
      sendLine(makeCmd(0, 0, 0, 0, 9));
      sendLine(makeCmd(319, -239, 319, -239, 10));
      sendLine(makeCmd(900, 900, 900, 900, 11));    // Fully outside.
      drain();
      finishTest("single point");

      startTest();
      bpOn <= 1'b1;
      repeat (20) begin
         randLine(-320, 319, -239, 240, c);
         sendLine(c);
      end
      drain();
      bpOn <= 1'b0;
      finishTest("random back-pressure");

      startTest();
      repeat (10) begin
         randLine(-40, 40, -40, 40, c);
         sendLine(c);                    // No idle cycle between commands.
      end
      drain();
      finishTest("back-to-back");

      $display("Summary: %0d lines, %0d pixels checked, %0d errors", lineCount, pixCount,
               errors);
      if (errors == 0 && !timedOut) begin
         $display("*** PASSED ***");
      end else begin
         if (timedOut) begin
            $display("The run stopped early because a wait timed out");
         end
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

// ==== flist.f ====
+incdir+include
design/rasterPkg.sv
design/pipeStage.sv
design/lineSetup.sv
design/bresenhamCore.sv
design/rasterFsm.sv
design/pixelAddresser.sv
design/lineRasterizer.sv
design/lineDrawTop.sv
tests/lineDrawTb.sv

// ==== Makefile ====
TOOL  = verilator
TOP   = lineDrawTb
FLIST = flist.f
FLAGS = --binary --timing --top-module $(TOP)
BUILD = obj_dir
LOG   = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) -f $(FLIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qF "*** PASSED ***" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
